//--- hw/video_pkg.sv
`default_nettype none

package video_pkg;

    // one pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // raw parallel input as it arrives on the pins
    typedef struct packed {
        logic    hsync_n;     // active low
        logic    vsync_n;     // active low
        logic    de;
        rgb888_t pix;
    } video_in_t;

    // aligned stream into the decimator
    typedef struct packed {
        logic    de;
        logic    line_end;    // first cycle after de falls
        logic    frame_start; // first cycle with vsync seen low
        rgb888_t pix;
    } video_beat_t;

endpackage

`default_nettype wire

//--- hw/fb_pkg.sv
`default_nettype none

package fb_pkg;

    // wide enough for a 320x180 buffer
    localparam int FB_ADDR_W = 16;

    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

    // single cycle write strobe into the frame buffer
    typedef struct packed {
        logic               we;
        fb_addr_t           addr;
        video_pkg::rgb888_t pix;
    } fb_wr_t;

endpackage

`default_nettype wire

//--- hw/video_rx_align.sv
`timescale 1ns/1ps
`default_nettype none

module video_rx_align (
    input  logic                   pclk,
    input  logic                   i_rst,
    input  video_pkg::video_in_t   i_video,
    output video_pkg::video_beat_t o_beat
);
    import video_pkg::*;

    logic    vsync_q;       // previous input cycle
    logic    de_q;
    logic    beat_de;
    logic    beat_line_end;
    logic    beat_frame_start;
    rgb888_t beat_pix;

    // edges are found against the previous input cycle
    always_ff @(posedge pclk) begin
        if (i_rst) begin
            vsync_q          <= 1'b1; // idle syncs are high
            de_q             <= 1'b0;
            beat_de          <= 1'b0;
            beat_line_end    <= 1'b0;
            beat_frame_start <= 1'b0;
        end else begin
            vsync_q          <= i_video.vsync_n;
            de_q             <= i_video.de;
            beat_de          <= i_video.de;
            beat_line_end    <= de_q & ~i_video.de;
            beat_frame_start <= vsync_q & ~i_video.vsync_n;
        end
    end

    // pixel payload just follows the input
    always_ff @(posedge pclk) begin
        beat_pix <= i_video.pix;
    end

    assign o_beat = '{
        de:          beat_de,
        line_end:    beat_line_end,
        frame_start: beat_frame_start,
        pix:         beat_pix
    };

    // the decimator counts lines per frame, so active video must stay
    // outside the vertical sync
    a_no_de_in_vsync: assert property (
        @(posedge pclk) disable iff (i_rst)
        !(i_video.de && !i_video.vsync_n)
    ) else $error("de high during vsync");

endmodule

`default_nettype wire

//--- hw/frame_decimator.sv
`timescale 1ns/1ps
`default_nettype none

module frame_decimator #(
    parameter int ACTIVE_COLS = 320,
    parameter int ACTIVE_ROWS = 180,
    parameter int H_DECIM     = 4,
    parameter int V_DECIM     = 4,
    parameter int F_DECIM     = 3
) (
    input  logic                   pclk,
    input  logic                   i_rst,
    input  video_pkg::video_beat_t i_beat,
    output fb_pkg::fb_wr_t         o_wr,
    output logic                   o_frame_start
);
    import video_pkg::*;
    import fb_pkg::*;

    localparam int COL_W = $clog2(ACTIVE_COLS + 1);
    localparam int ROW_W = $clog2(ACTIVE_ROWS + 1);
    localparam int FPH_W = (F_DECIM > 1) ? $clog2(F_DECIM) : 1;
    localparam int VPH_W = (V_DECIM > 1) ? $clog2(V_DECIM) : 1;
    localparam int HPH_W = (H_DECIM > 1) ? $clog2(H_DECIM) : 1;

    localparam logic [COL_W-1:0] COL_END  = COL_W'(ACTIVE_COLS);
    localparam logic [ROW_W-1:0] ROW_END  = ROW_W'(ACTIVE_ROWS);
    localparam logic [FPH_W-1:0] FPH_LAST = FPH_W'(F_DECIM - 1);
    localparam logic [VPH_W-1:0] VPH_LAST = VPH_W'(V_DECIM - 1);
    localparam logic [HPH_W-1:0] HPH_LAST = HPH_W'(H_DECIM - 1);
    localparam fb_addr_t         ROW_STEP = fb_addr_t'(ACTIVE_COLS);

    logic [FPH_W-1:0] frame_ph;
    logic             frame_keep;   // current frame is captured
    logic [VPH_W-1:0] line_ph;
    logic [VPH_W-1:0] line_ph_nxt;
    logic             line_keep;    // current line is captured
    logic [HPH_W-1:0] pix_ph;
    logic [COL_W-1:0] col;          // saturates at ACTIVE_COLS
    logic [ROW_W-1:0] row;
    logic [ROW_W-1:0] row_nxt;
    fb_addr_t         row_base;
    logic             pix_keep;

    logic             wr_we;
    fb_addr_t         wr_addr;
    rgb888_t          wr_pix;
    logic             fs_q;

    assign line_ph_nxt = (line_ph == VPH_LAST) ? '0 : line_ph + 1'b1;
    assign row_nxt     = line_keep ? row + 1'b1 : row;

    // all four rules have to agree
    assign pix_keep = i_beat.de && frame_keep && line_keep &&
                      (pix_ph == '0) && (col < COL_END);

    always_ff @(posedge pclk) begin
        if (i_rst) begin
            frame_ph   <= '0;       // first frame after reset is kept
            frame_keep <= 1'b0;
            line_ph    <= '0;
            line_keep  <= 1'b0;
            pix_ph     <= '0;
            col        <= '0;
            row        <= '0;
            row_base   <= '0;
            wr_we      <= 1'b0;
            fs_q       <= 1'b0;
        end else begin
            wr_we <= pix_keep;
            fs_q  <= i_beat.frame_start && (frame_ph == '0);

            if (i_beat.frame_start) begin
                frame_keep <= (frame_ph == '0);
                frame_ph   <= (frame_ph == FPH_LAST) ? '0 : frame_ph + 1'b1;
                line_ph    <= '0;
                line_keep  <= 1'b1;
                pix_ph     <= '0;
                col        <= '0;
                row        <= '0;
                row_base   <= '0;
            end else if (i_beat.line_end) begin
                line_ph   <= line_ph_nxt;
                line_keep <= (line_ph_nxt == '0) && (row_nxt < ROW_END);
                pix_ph    <= '0;
                col       <= '0;
                if (line_keep) begin
                    row      <= row_nxt;
                    row_base <= row_base + ROW_STEP; // next output row
                end
            end else if (i_beat.de) begin
                pix_ph <= (pix_ph == HPH_LAST) ? '0 : pix_ph + 1'b1;
                if ((pix_ph == '0) && (col < COL_END)) begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // write payload
    always_ff @(posedge pclk) begin
        if (pix_keep) begin
            wr_addr <= row_base + fb_addr_t'(col);
            wr_pix  <= i_beat.pix;
        end
    end

    assign o_wr = '{
        we:   wr_we,
        addr: wr_addr,
        pix:  wr_pix
    };
    assign o_frame_start = fs_q;

    a_addr_in_frame: assert property (
        @(posedge pclk) disable iff (i_rst)
        o_wr.we |-> (int'(o_wr.addr) < ACTIVE_COLS * ACTIVE_ROWS)
    ) else $error("write beyond the output frame");

    // relies on the input side keeping de out of vsync
    a_fs_not_with_we: assert property (
        @(posedge pclk) disable iff (i_rst)
        !(o_frame_start && o_wr.we)
    ) else $error("frame start together with a write");

endmodule

`default_nettype wire

//--- hw/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int DEPTH = 320 * 180
) (
    input  logic               pclk,
    input  fb_pkg::fb_wr_t     i_wr,
    input  fb_pkg::fb_addr_t   i_rd_addr,
    output video_pkg::rgb888_t o_rd_data
);
    import video_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rgb888_t        mem [DEPTH];
    logic [AW-1:0]  wr_idx;
    logic [AW-1:0]  rd_idx;

    assign wr_idx = i_wr.addr[AW-1:0];
    assign rd_idx = i_rd_addr[AW-1:0];

    // simple dual port, old data on a same address collision
    always_ff @(posedge pclk) begin
        if (i_wr.we) begin
            mem[wr_idx] <= i_wr.pix;
        end
        o_rd_data <= mem[rd_idx];
    end

    a_wr_in_range: assert property (
        @(posedge pclk)
        i_wr.we |-> (int'(i_wr.addr) < DEPTH)
    ) else $error("frame buffer write out of range");

endmodule

`default_nettype wire

//--- hw/capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_top #(
    parameter int ACTIVE_COLS = 320,
    parameter int ACTIVE_ROWS = 180,
    parameter int H_DECIM     = 4,
    parameter int V_DECIM     = 4,
    parameter int F_DECIM     = 3
) (
    input  logic                 pclk,
    input  logic                 i_rst,
    input  video_pkg::video_in_t i_video,
    input  fb_pkg::fb_addr_t     i_rd_addr,
    output video_pkg::rgb888_t   o_rd_data,
    output logic                 o_frame_start
);
    import video_pkg::*;
    import fb_pkg::*;

    localparam int DEPTH = ACTIVE_COLS * ACTIVE_ROWS;

    video_beat_t beat;
    fb_wr_t      wr;

    // input side
    video_rx_align video_rx_align_i (
        .pclk    (pclk),
        .i_rst   (i_rst),
        .i_video (i_video),
        .o_beat  (beat)
    );

    frame_decimator #(
        .ACTIVE_COLS (ACTIVE_COLS),
        .ACTIVE_ROWS (ACTIVE_ROWS),
        .H_DECIM     (H_DECIM),
        .V_DECIM     (V_DECIM),
        .F_DECIM     (F_DECIM)
    ) frame_decimator_i (
        .pclk          (pclk),
        .i_rst         (i_rst),
        .i_beat        (beat),
        .o_wr          (wr),
        .o_frame_start (o_frame_start)
    );

    // one word per output pixel
    frame_buffer #(
        .DEPTH (DEPTH)
    ) frame_buffer_i (
        .pclk      (pclk),
        .i_wr      (wr),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

//--- tb/tb_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_capture_top;
    import video_pkg::*;
    import fb_pkg::*;

    localparam int COLS  = 8;
    localparam int ROWS  = 6;
    localparam int HD    = 4;
    localparam int VD    = 4;
    localparam int FD    = 3;
    localparam int DEPTH = COLS * ROWS;
    localparam int MAX_W = 40;
    localparam int MAX_H = 30;

    // blanking lengths in pclk cycles
    localparam int VS_LEN   = 3;
    localparam int VBP_LEN  = 2;
    localparam int HS_LEN   = 2;
    localparam int HBP_LEN  = 3;
    localparam int HFP_LEN  = 2;
    localparam int TAIL_LEN = 4;
    localparam int IDLE_LEN = 10;

    logic        pclk = 1'b0;
    logic        rst = 1'b1;
    video_in_t   video;
    fb_addr_t    rd_addr;
    rgb888_t     rd_data;
    logic        frame_start;

    int          cyc = 0;
    int          cyc_limit = 1000;
    int          errors = 0;
    int          checks = 0;
    int          frame_no = 0;
    int          fs_count = 0;
    int          fs_cyc = 0;
    int          vs_cyc = 0;
    logic        fs_prev = 1'b0;
    logic [31:0] lfsr;

    rgb888_t     shadow [MAX_H][MAX_W]; // last frame as it was sent
    rgb888_t     exp_fb [DEPTH];        // expected buffer contents

    capture_top #(
        .ACTIVE_COLS (COLS),
        .ACTIVE_ROWS (ROWS),
        .H_DECIM     (HD),
        .V_DECIM     (VD),
        .F_DECIM     (FD)
    ) capture_top_i (
        .pclk          (pclk),
        .i_rst         (rst),
        .i_video       (video),
        .i_rd_addr     (rd_addr),
        .o_rd_data     (rd_data),
        .o_frame_start (frame_start)
    );

    always #4 pclk = ~pclk;

    always @(posedge pclk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout: run did not finish within %0d cycles", cyc_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_pix(input rgb888_t got, input rgb888_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // frame start pulses, looked at on the falling edge
    always @(negedge pclk) begin
        if (rst) begin
            check_bit(frame_start, 1'b0, "o_frame_start during reset");
        end else begin
            check_bit(frame_start && fs_prev, 1'b0, "o_frame_start longer than one cycle");
            if (frame_start) begin
                fs_count <= fs_count + 1;
                fs_cyc   <= cyc;
            end
        end
        fs_prev <= frame_start;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_pix(output rgb888_t p);
        logic [23:0] bits;
        for (int i = 0; i < 24; i++) begin
            lfsr    = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        p = bits;
    endtask

    function automatic rgb888_t pattern_pix(input int x, input int y, input logic [7:0] variant);
        rgb888_t p;
        p.r = 8'(x) ^ variant;
        p.g = 8'(y);
        p.b = 8'(x * 7 + y * 13);
        return p;
    endfunction

    function automatic int frame_cycles(input int w, input int h);
        return VS_LEN + VBP_LEN + h * (HS_LEN + HBP_LEN + w + HFP_LEN) + TAIL_LEN;
    endfunction

    task automatic drive(input logic hs_n, input logic vs_n, input logic de, input rgb888_t pix);
        @(negedge pclk);
        video = '{hsync_n: hs_n, vsync_n: vs_n, de: de, pix: pix};
    endtask

    // keep every HD-th pixel of every VD-th line, clipped to the buffer
    task automatic update_model(input int w, input int h);
        for (int y = 0; y < h; y += VD) begin
            for (int x = 0; x < w; x += HD) begin
                if ((x / HD) < COLS && (y / VD) < ROWS) begin
                    exp_fb[(y / VD) * COLS + x / HD] = shadow[y][x];
                end
            end
        end
    endtask

    task automatic send_frame(input int w, input int h, input bit use_lfsr,
                              input logic [7:0] variant);
        int      fs_before;
        bit      kept;
        rgb888_t p;
        fs_before = fs_count;
        kept      = (frame_no % FD) == 0;
        for (int i = 0; i < VS_LEN; i++) begin
            drive(1'b1, 1'b0, 1'b0, '0);
            if (i == 0) begin
                vs_cyc = cyc; // sampled by the next rising edge
            end
        end
        for (int i = 0; i < VBP_LEN; i++) begin
            drive(1'b1, 1'b1, 1'b0, '0);
        end
        for (int y = 0; y < h; y++) begin
            for (int i = 0; i < HS_LEN; i++) begin
                drive(1'b0, 1'b1, 1'b0, '0);
            end
            for (int i = 0; i < HBP_LEN; i++) begin
                drive(1'b1, 1'b1, 1'b0, '0);
            end
            for (int x = 0; x < w; x++) begin
                if (use_lfsr) begin
                    rand_pix(p);
                end else begin
                    p = pattern_pix(x, y, variant);
                end
                shadow[y][x] = p;
                drive(1'b1, 1'b1, 1'b1, p);
            end
            for (int i = 0; i < HFP_LEN; i++) begin
                drive(1'b1, 1'b1, 1'b0, '0);
            end
        end
        for (int i = 0; i < TAIL_LEN; i++) begin
            drive(1'b1, 1'b1, 1'b0, '0); // lets the last write land
        end
        if (kept) begin
            update_model(w, h);
            check_count(fs_count, fs_before + 1, $sformatf("frame %0d start pulses", frame_no));
            // pulse seen two edges after the one that sampled vsync low
            check_count(fs_cyc, vs_cyc + 2, $sformatf("frame %0d start cycle", frame_no));
        end else begin
            check_count(fs_count, fs_before, $sformatf("skipped frame %0d pulses", frame_no));
        end
        frame_no++;
    endtask

    task automatic readback(input string tag);
        for (int a = 0; a < DEPTH; a++) begin
            @(negedge pclk);
            rd_addr = fb_addr_t'(a);
            @(negedge pclk);
            check_pix(rd_data, exp_fb[a], $sformatf("%s addr %0d", tag, a));
        end
    endtask

    task automatic test_reset();
        repeat (3) @(negedge pclk);
        rst = 1'b0;
        for (int i = 0; i < IDLE_LEN; i++) begin
            drive(1'b1, 1'b1, 1'b0, '0);
        end
        check_count(fs_count, 0, "frame start pulses before the first frame");
    endtask

    task automatic test_kept_frame();
        send_frame(32, 24, 1'b0, 8'h00);
        readback("frame 0");
    endtask

    // frames 1 and 2 must leave the buffer alone
    task automatic test_frame_skip();
        send_frame(32, 24, 1'b0, 8'h5a);
        send_frame(32, 24, 1'b0, 8'ha5);
        readback("after skipped frames");
    endtask

    task automatic test_random_oversize();
        send_frame(MAX_W, MAX_H, 1'b1, 8'h00);
        readback("oversize random frame");
    endtask

    initial begin
        video   = '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0, pix: '0};
        rd_addr = '0;
        lfsr    = 32'h26e5_637e;
        cyc_limit = 2 * (3 + IDLE_LEN + 3 * frame_cycles(32, 24) +
                         frame_cycles(MAX_W, MAX_H) + 3 * (2 * DEPTH) + 2);

        test_reset();
        test_kept_frame();
        test_frame_skip();
        test_random_oversize();

        repeat (2) @(negedge pclk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/video_pkg.sv
hw/fb_pkg.sv
hw/video_rx_align.sv
hw/frame_decimator.sv
hw/frame_buffer.sv
hw/capture_top.sv
tb/tb_capture_top.sv

//--- Makefile
SRCS = $(shell cat sources.f)

obj_dir/Vtb_capture_top: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_capture_top -f sources.f

sim.log: obj_dir/Vtb_capture_top
	./obj_dir/Vtb_capture_top > sim.log 2>&1 || true

run: obj_dir/Vtb_capture_top
	./obj_dir/Vtb_capture_top > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
